/* Bender.yml */
package:
  name: gbt_link

sources:
  - files:
      - logic/gbt_pkg.sv
      - logic/gbt_frame_rx.sv
      - logic/ttc_decoder.sv
      - logic/gbt_axil_master.sv
      - logic/gbt_reg_file.sv
      - logic/gbt_frame_tx.sv
      - logic/gbt_link_top.sv
  - target: test
    files:
      - test/gbt_link_tb.sv

/* logic/gbt_axil_master.sv */
`timescale 1ns/1ps

module gbt_axil_master import gbt_pkg::*; (
  input  logic      clk40,
  input  logic      rst_n_i,
  input  logic      req_valid_i,
  input  gbt_req_t  req_i,
  output axil_req_t axil_o,
  input  axil_rsp_t axil_i,
  output logic      rsp_valid_o,
  output gbt_rsp_t  rsp_o,
  input  logic      rsp_ready_i
);

  gbt_req_t buf_req_q;
  gbt_req_t act_req_q;
  logic     buf_valid_q;
  logic     act_q;       // a transaction is in flight
  logic     aw_pend_q;
  logic     w_pend_q;
  logic     ar_pend_q;
  logic     load;
  logic     take;
  logic     rd_active;
  logic     wr_done;
  logic     rd_done;

  assign load      = buf_valid_q && !act_q;
  assign take      = req_valid_i && (!buf_valid_q || load); // full buffer drops the request
  assign rd_active = act_q && !act_req_q.we;
  assign wr_done   = act_q && act_req_q.we && axil_i.bvalid;
  assign rd_done   = rd_active && axil_i.rvalid && rsp_ready_i;

  // ----------------------------------------
  // one-entry request buffer
  // ----------------------------------------

  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      buf_valid_q <= 1'b0;
    end else if (take) begin
      buf_valid_q <= 1'b1;
    end else if (load) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk40) begin
    if (take) begin
      buf_req_q <= req_i;
    end
    if (load) begin
      act_req_q <= buf_req_q;
    end
  end

  // ----------------------------------------
  // active transaction
  // ----------------------------------------

  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      act_q     <= 1'b0;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      ar_pend_q <= 1'b0;
    end else if (load) begin
      act_q     <= 1'b1;
      aw_pend_q <= buf_req_q.we;
      w_pend_q  <= buf_req_q.we;
      ar_pend_q <= !buf_req_q.we;
    end else begin
      if (aw_pend_q && axil_i.awready) aw_pend_q <= 1'b0;
      if (w_pend_q && axil_i.wready)   w_pend_q  <= 1'b0;
      if (ar_pend_q && axil_i.arready) ar_pend_q <= 1'b0;
      if (wr_done || rd_done)          act_q     <= 1'b0;
    end
  end

  always_comb begin
    axil_o         = '0;
    axil_o.awvalid = aw_pend_q;
    axil_o.awaddr  = act_req_q.addr;
    axil_o.wvalid  = w_pend_q;
    axil_o.wdata   = act_req_q.data;
    axil_o.bready  = act_q && act_req_q.we;
    axil_o.arvalid = ar_pend_q;
    axil_o.araddr  = act_req_q.addr;
    axil_o.rready  = rd_active && rsp_ready_i; // stall reads while tx busy
  end

  // read data goes straight to the transmitter
  assign rsp_valid_o = axil_i.rvalid;
  assign rsp_o.err   = |axil_i.rresp;
  assign rsp_o.addr  = act_req_q.addr;
  assign rsp_o.data  = axil_i.rdata;

  a_aw_hold: assert property (
    @(posedge clk40) disable iff (!rst_n_i)
    axil_o.awvalid && !axil_i.awready |=> axil_o.awvalid
  );

endmodule

/* logic/gbt_frame_rx.sv */
`timescale 1ns/1ps

module gbt_frame_rx import gbt_pkg::*; (
  input  logic     clk40,
  input  logic     rst_n_i,
  input  frame_t   frame_i,
  output ttc_t     ttc_o,
  output logic     req_valid_o,
  output gbt_req_t req_o
);

  localparam logic [3:0] LAST_BODY = 4'(PKT_BODY - 1);

  rx_state_e             state_q;
  logic [3:0]            body_cnt_q;
  logic [PKT_BITS-1:0]   shift_q;     // payloads, first frame on top
  logic                  req_valid_q;
  ttc_t                  ttc_q;
  payload_t              payload;

  assign payload = frame_i[5:0];

  // ----------------------------------------
  // packet framing
  // ----------------------------------------

  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      state_q     <= RX_HUNT;
      body_cnt_q  <= '0;
      req_valid_q <= 1'b0;
      ttc_q       <= '0;
    end else begin
      ttc_q       <= ttc_t'(frame_i[9:6]); // every frame in or out of a packet
      req_valid_q <= 1'b0;
      case (state_q)
        RX_HUNT: begin
          if (payload == START_MARK) begin
            state_q    <= RX_BODY;
            body_cnt_q <= '0;
          end
        end
        RX_BODY: begin
          body_cnt_q <= body_cnt_q + 4'd1;
          if (body_cnt_q == LAST_BODY) begin
            state_q     <= RX_HUNT;
            req_valid_q <= shift_q[PKT_BITS-7]; // valid bit sits one shift short of the top
          end
        end
        default: state_q <= RX_HUNT;
      endcase
    end
  end

  // markers inside the body are plain data
  always_ff @(posedge clk40) begin
    if (state_q == RX_BODY) begin
      shift_q <= {shift_q[PKT_BITS-7:0], payload};
    end
  end

  assign ttc_o       = ttc_q;
  assign req_valid_o = req_valid_q;
  assign req_o.we    = shift_q[64];
  assign req_o.addr  = shift_q[63:32];
  assign req_o.data  = shift_q[31:0];

  // a packet needs twelve frames, so requests cannot come back to back
  a_req_single: assert property (
    @(posedge clk40) disable iff (!rst_n_i)
    req_valid_o |=> !req_valid_o
  );

endmodule

/* logic/gbt_frame_tx.sv */
`timescale 1ns/1ps

module gbt_frame_tx import gbt_pkg::*; (
  input  logic     clk40,
  input  logic     rst_n_i,
  input  logic     rsp_valid_i,
  input  gbt_rsp_t rsp_i,
  output logic     rsp_ready_o,
  output frame_t   frame_o
);

  localparam logic [3:0] LAST_BODY = 4'(PKT_BODY - 1);

  logic                busy_q;
  logic [3:0]          frm_cnt_q;
  logic [PKT_BITS-1:0] shift_q;    // flag, err, addr, data
  frame_t              frame_q;
  logic                start;

  assign rsp_ready_o = !busy_q;
  assign start       = rsp_valid_i && !busy_q;

  // ----------------------------------------
  // frame sequencer
  // ----------------------------------------

  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      frm_cnt_q <= '0;
      frame_q   <= '0;                        // idle frame
    end else if (start) begin
      busy_q    <= 1'b1;
      frm_cnt_q <= '0;
      frame_q   <= {4'b0000, START_MARK};
    end else if (busy_q) begin
      frm_cnt_q <= frm_cnt_q + 4'd1;
      frame_q   <= {4'b0000, shift_q[PKT_BITS-1 -: 6]}; // msb field first
      if (frm_cnt_q == LAST_BODY) begin
        busy_q <= 1'b0;
      end
    end else begin
      frame_q <= '0;
    end
  end

  always_ff @(posedge clk40) begin
    if (start) begin
      shift_q <= {1'b1, rsp_i.err, rsp_i.addr, rsp_i.data};
    end else if (busy_q) begin
      shift_q <= {shift_q[PKT_BITS-7:0], 6'b000000};
    end
  end

  assign frame_o = frame_q;

endmodule

/* logic/gbt_link_top.sv */
`timescale 1ns/1ps

module gbt_link_top import gbt_pkg::*; (
  input  logic   clk40,
  input  logic   rst_n_i,
  input  frame_t gbt_rx_data_i,
  output frame_t gbt_tx_data_o,
  output ttc_t   ttc_pulse_o,
  output bx_t    bx_cnt_o
);

  ttc_t      ttc;
  logic      req_valid;
  gbt_req_t  req;
  l1a_cnt_t  l1a_cnt;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  logic      rsp_valid;
  logic      rsp_ready;
  gbt_rsp_t  rsp;

  // ----------------------------------------
  // receive side
  // ----------------------------------------

  gbt_frame_rx rx_i (
    .clk40       (clk40),
    .rst_n_i     (rst_n_i),
    .frame_i     (gbt_rx_data_i),
    .ttc_o       (ttc),
    .req_valid_o (req_valid),
    .req_o       (req)
  );

  ttc_decoder ttc_i (
    .clk40       (clk40),
    .rst_n_i     (rst_n_i),
    .ttc_i       (ttc),
    .ttc_pulse_o (ttc_pulse_o),
    .bx_cnt_o    (bx_cnt_o),
    .l1a_cnt_o   (l1a_cnt)
  );

  // ----------------------------------------
  // bus and transmit side
  // ----------------------------------------

  gbt_axil_master master_i (
    .clk40       (clk40),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid),
    .req_i       (req),
    .axil_o      (axil_req),
    .axil_i      (axil_rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .rsp_ready_i (rsp_ready)
  );

  gbt_reg_file regs_i (
    .clk40     (clk40),
    .rst_n_i   (rst_n_i),
    .axil_i    (axil_req),
    .axil_o    (axil_rsp),
    .l1a_cnt_i (l1a_cnt)
  );

  gbt_frame_tx tx_i (
    .clk40       (clk40),
    .rst_n_i     (rst_n_i),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp),
    .rsp_ready_o (rsp_ready),
    .frame_o     (gbt_tx_data_o)
  );

endmodule

/* logic/gbt_pkg.sv */
package gbt_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  typedef logic [9:0]  frame_t;   // ttc in 9:6, payload in 5:0
  typedef logic [5:0]  payload_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [11:0] bx_t;
  typedef logic [31:0] l1a_cnt_t;

  // ----------------------------------------
  // frame format and register map
  // ----------------------------------------

  localparam payload_t   START_MARK  = 6'h2A;
  localparam int         PKT_BODY    = 11;            // frames after the marker
  localparam int         PKT_BITS    = PKT_BODY * 6;  // valid/flag + we + addr + data
  localparam bx_t        BX_MAX      = 12'd3563;
  localparam logic [7:0] REG_BASE    = 8'h40;         // addr 31:24 of the bank
  localparam int         NUM_REGS    = 16;
  localparam int         REG_IDX_W   = $clog2(NUM_REGS);
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // ----------------------------------------
  // bundles
  // ----------------------------------------

  typedef struct packed {
    logic l1a;       // frame bit 9
    logic calpulse;
    logic resync;
    logic bc0;       // frame bit 6
  } ttc_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t data;
  } gbt_req_t;

  typedef struct packed {
    logic  err;
    addr_t addr;
    word_t data;
  } gbt_rsp_t;

  typedef struct packed {
    logic       awvalid;
    addr_t      awaddr;
    logic       wvalid;
    word_t      wdata;
    logic       bready;
    logic       arvalid;
    addr_t      araddr;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    word_t      rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  typedef enum logic {
    RX_HUNT,
    RX_BODY
  } rx_state_e;

endpackage

/* logic/gbt_reg_file.sv */
`timescale 1ns/1ps

module gbt_reg_file import gbt_pkg::*; (
  input  logic      clk40,
  input  logic      rst_n_i,
  input  axil_req_t axil_i,
  output axil_rsp_t axil_o,
  input  l1a_cnt_t  l1a_cnt_i
);

  word_t                regs_q [1:NUM_REGS-1]; // reg 0 is the l1a count
  logic                 bvalid_q;
  logic                 rvalid_q;
  logic [1:0]           bresp_q;
  logic [1:0]           rresp_q;
  word_t                rdata_q;
  logic                 wr_take;
  logic                 rd_take;
  logic                 wr_ok;
  logic                 rd_ok;
  logic [REG_IDX_W-1:0] wr_idx;
  logic [REG_IDX_W-1:0] rd_idx;
  word_t                rd_word;

  function automatic logic addr_in_bank(addr_t a);
    return (a[31:24] == REG_BASE) && (a[23:6] == '0);
  endfunction

  assign wr_take = axil_i.awvalid && axil_i.wvalid && !bvalid_q;
  assign rd_take = axil_i.arvalid && !rvalid_q;
  assign wr_ok   = addr_in_bank(axil_i.awaddr);
  assign rd_ok   = addr_in_bank(axil_i.araddr);
  assign wr_idx  = axil_i.awaddr[REG_IDX_W+1:2];
  assign rd_idx  = axil_i.araddr[REG_IDX_W+1:2];

  always_comb begin
    if (!rd_ok) begin
      rd_word = '0;
    end else if (rd_idx == '0) begin
      rd_word = l1a_cnt_i;
    end else begin
      rd_word = regs_q[rd_idx];
    end
  end

  // ----------------------------------------
  // write channel
  // ----------------------------------------

  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_take) begin
      bvalid_q <= 1'b1;
      if (wr_ok && (wr_idx != '0)) begin // reg 0 silently read-only
        regs_q[wr_idx] <= axil_i.wdata;
      end
    end else if (axil_i.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  // ----------------------------------------
  // read channel
  // ----------------------------------------

  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_take) begin
      rvalid_q <= 1'b1;
    end else if (axil_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk40) begin
    if (wr_take) begin
      bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_take) begin
      rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      rdata_q <= rd_word;
    end
  end

  assign axil_o.awready = wr_take;
  assign axil_o.wready  = wr_take;
  assign axil_o.bvalid  = bvalid_q;
  assign axil_o.bresp   = bresp_q;
  assign axil_o.arready = rd_take;
  assign axil_o.rvalid  = rvalid_q;
  assign axil_o.rdata   = rdata_q;
  assign axil_o.rresp   = rresp_q;

  a_r_hold: assert property (
    @(posedge clk40) disable iff (!rst_n_i)
    axil_o.rvalid && !axil_i.rready |=> axil_o.rvalid && $stable(axil_o.rdata)
  );

endmodule

/* logic/ttc_decoder.sv */
`timescale 1ns/1ps

module ttc_decoder import gbt_pkg::*; (
  input  logic     clk40,
  input  logic     rst_n_i,
  input  ttc_t     ttc_i,
  output ttc_t     ttc_pulse_o,
  output bx_t      bx_cnt_o,
  output l1a_cnt_t l1a_cnt_o
);

  ttc_t     pulse_q;
  bx_t      bx_q;
  l1a_cnt_t l1a_q;

  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      pulse_q <= '0;
      bx_q    <= '0;
      l1a_q   <= '0;
    end else begin
      pulse_q <= ttc_i;

      if (ttc_i.bc0 || (bx_q == BX_MAX)) begin
        bx_q <= '0;             // orbit start or wrap
      end else begin
        bx_q <= bx_q + 12'd1;
      end

      if (ttc_i.resync) begin
        l1a_q <= '0;            // resync beats a coincident l1a
      end else if (ttc_i.l1a) begin
        l1a_q <= l1a_q + 32'd1;
      end
    end
  end

  assign ttc_pulse_o = pulse_q;
  assign bx_cnt_o    = bx_q;
  assign l1a_cnt_o   = l1a_q;

  a_bx_range: assert property (
    @(posedge clk40) disable iff (!rst_n_i)
    bx_cnt_o <= BX_MAX
  );

endmodule

/* project.f */
logic/gbt_pkg.sv
logic/gbt_frame_rx.sv
logic/ttc_decoder.sv
logic/gbt_axil_master.sv
logic/gbt_reg_file.sv
logic/gbt_frame_tx.sv
logic/gbt_link_top.sv
test/gbt_link_tb.sv

/* test/gbt_link_tb.sv */
`timescale 1ns/1ps

module gbt_link_tb import gbt_pkg::*; ();

  localparam int   N_PACKETS   = 29;
  localparam int   N_IDLE      = 3700;  // noise, ttc and bx wrap stretches
  localparam int   TIMEOUT_CYC = N_PACKETS * 30 + N_IDLE + 300;
  localparam ttc_t TTC_NONE    = 4'b0000;
  localparam ttc_t TTC_L1A     = 4'b1000;
  localparam ttc_t TTC_CAL     = 4'b0100;
  localparam ttc_t TTC_RES_L1A = 4'b1010; // resync and l1a together
  localparam ttc_t TTC_BC0     = 4'b0001;

  logic                clk40;
  logic                rst_n_i;
  frame_t              gbt_rx_data_i;
  frame_t              gbt_tx_data_o;
  ttc_t                ttc_pulse_o;
  bx_t                 bx_cnt_o;
  logic [15:0]         lfsr_q;
  word_t               reg_model [0:NUM_REGS-1];
  int                  l1a_model;
  gbt_rsp_t            exp_q [$];           // reads still owed a response
  logic                col_active;
  logic [3:0]          col_cnt;
  logic [PKT_BITS-1:0] col_bits;
  logic [PKT_BITS-1:0] got_bits;
  logic                rsp_done;
  logic                exp_ok;
  gbt_rsp_t            exp_rsp;
  ttc_t                ttc_d1;
  ttc_t                ttc_d2;
  bx_t                 bx_model;

  gbt_link_top dut_i (
    .clk40         (clk40),
    .rst_n_i       (rst_n_i),
    .gbt_rx_data_i (gbt_rx_data_i),
    .gbt_tx_data_o (gbt_tx_data_o),
    .ttc_pulse_o   (ttc_pulse_o),
    .bx_cnt_o      (bx_cnt_o)
  );

  initial begin
    clk40 = 1'b0;
    forever #4 clk40 = ~clk40;
  end

  task automatic stop_run();
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_value(string name, logic [31:0] exp, logic [31:0] got);
    $display("error %s expected %h got %h", name, exp, got);
    stop_run();
  endtask

  task automatic report_fault(string what);
    $display("%s", what);
    stop_run();
  endtask

  // ----------------------------------------
  // reference models and tx collector
  // ----------------------------------------

  always @(posedge clk40) begin
    if (!rst_n_i) begin
      ttc_d1   <= '0;
      ttc_d2   <= '0;
      bx_model <= '0;
    end else begin
      ttc_d1 <= ttc_t'(gbt_rx_data_i[9:6]);
      ttc_d2 <= ttc_d1;                      // rx register then decoder register
      if (ttc_d1.bc0 || (bx_model == BX_MAX)) begin
        bx_model <= '0;
      end else begin
        bx_model <= bx_model + 12'd1;
      end
    end
  end

  always @(posedge clk40) begin : collect
    logic [PKT_BITS-1:0] shifted;
    shifted  = {col_bits[PKT_BITS-7:0], gbt_tx_data_o[5:0]};
    rsp_done <= 1'b0;
    if (!rst_n_i) begin
      col_active <= 1'b0;
      col_cnt    <= '0;
      exp_ok     <= 1'b0;
    end else if (!col_active) begin
      if (gbt_tx_data_o[5:0] == START_MARK) begin
        col_active <= 1'b1;
        col_cnt    <= '0;
      end
    end else begin
      col_bits <= shifted;
      col_cnt  <= col_cnt + 4'd1;
      if (col_cnt == 4'(PKT_BODY - 1)) begin // last body frame
        col_active <= 1'b0;
        rsp_done   <= 1'b1;
        got_bits   <= shifted;
        exp_ok     <= (exp_q.size() != 0);
        if (exp_q.size() != 0) exp_rsp <= exp_q.pop_front();
      end
    end
  end

  a_bx_model: assert property (@(posedge clk40) disable iff (!rst_n_i)
    bx_cnt_o == bx_model)
    else report_value("bx_cnt_o", $sampled(bx_model), $sampled(bx_cnt_o));
  a_ttc_pulse: assert property (@(posedge clk40) disable iff (!rst_n_i)
    ttc_pulse_o == ttc_d2)
    else report_value("ttc_pulse_o", $sampled(ttc_d2), $sampled(ttc_pulse_o));
  a_tx_ttc: assert property (@(posedge clk40) disable iff (!rst_n_i)
    gbt_tx_data_o[9:6] == 4'b0000)
    else report_value("gbt_tx_data_o ttc", 32'd0, $sampled(gbt_tx_data_o[9:6]));
  a_tx_idle: assert property (@(posedge clk40) disable iff (!rst_n_i)
    !col_active |-> (gbt_tx_data_o[5:0] == 6'h00) || (gbt_tx_data_o[5:0] == START_MARK))
    else report_value("gbt_tx_data_o idle", 32'd0, $sampled(gbt_tx_data_o[5:0]));
  a_rsp_owed: assert property (@(posedge clk40) disable iff (!rst_n_i)
    rsp_done |-> exp_ok)
    else report_fault("a response packet arrived while no read was outstanding");
  a_rsp_flag: assert property (@(posedge clk40) disable iff (!rst_n_i)
    rsp_done |-> got_bits[65])
    else report_value("rsp flag", 32'd1, $sampled(got_bits[65]));
  a_rsp_err: assert property (@(posedge clk40) disable iff (!rst_n_i)
    rsp_done && exp_ok |-> got_bits[64] == exp_rsp.err)
    else report_value("rsp err", $sampled(exp_rsp.err), $sampled(got_bits[64]));
  a_rsp_addr: assert property (@(posedge clk40) disable iff (!rst_n_i)
    rsp_done && exp_ok |-> got_bits[63:32] == exp_rsp.addr)
    else report_value("rsp addr", $sampled(exp_rsp.addr), $sampled(got_bits[63:32]));
  a_rsp_data: assert property (@(posedge clk40) disable iff (!rst_n_i)
    rsp_done && exp_ok |-> got_bits[31:0] == exp_rsp.data)
    else report_value("rsp data", $sampled(exp_rsp.data), $sampled(got_bits[31:0]));

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------

  function automatic logic [31:0] next_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic addr_t reg_addr(int idx);
    return {REG_BASE, 18'd0, 4'(idx), 2'b00};
  endfunction

  function automatic logic bank_hit(addr_t a);
    return (a[31:24] == REG_BASE) && (a[23:6] == 18'd0);
  endfunction

  task automatic send_frame(ttc_t t, payload_t p);
    @(negedge clk40);
    gbt_rx_data_i = {t, p};
  endtask

  task automatic send_request(logic valid, logic we, addr_t a, word_t d);
    logic [PKT_BITS-1:0] bits;
    bits = {valid, we, a, d};
    send_frame(TTC_NONE, START_MARK);
    for (int i = 0; i < PKT_BODY; i++) begin
      send_frame(TTC_NONE, bits[PKT_BITS-1-6*i -: 6]); // msb field first
    end
    send_frame(TTC_NONE, 6'h00);
  endtask

  task automatic write_word(addr_t a, word_t d);
    if (bank_hit(a) && (a[5:2] != 4'd0)) reg_model[a[5:2]] = d;
    send_request(1'b1, 1'b1, a, d);
  endtask

  task automatic read_word(addr_t a);
    gbt_rsp_t rsp;
    rsp.addr = a;
    rsp.err  = !bank_hit(a);
    if (!bank_hit(a)) rsp.data = '0;
    else if (a[5:2] == 4'd0) rsp.data = word_t'(l1a_model);
    else rsp.data = reg_model[a[5:2]];
    exp_q.push_back(rsp);
    send_request(1'b1, 1'b0, a, next_bits(32)); // data field unused on reads
  endtask

  task automatic send_noise(int n);
    payload_t p;
    repeat (n) begin
      p = payload_t'(next_bits(6));
      if (p == START_MARK) p = 6'h15;         // keep the hunter idle
      send_frame(TTC_NONE, p);
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial begin
    int    idx;
    int    k;
    word_t d;
    addr_t a;
    rst_n_i       = 1'b0;
    gbt_rx_data_i = '0;
    lfsr_q        = 16'd40154;
    l1a_model     = 0;
    for (int i = 0; i < NUM_REGS; i++) reg_model[i] = '0;
    repeat (4) @(negedge clk40);
    rst_n_i = 1'b1;
    send_frame(TTC_BC0, 6'h00);

    for (int n = 0; n < 6; n++) begin       // random write then read back
      idx = 1 + int'(next_bits(4)) % 15;
      write_word(reg_addr(idx), next_bits(32));
      read_word(reg_addr(idx));
      if (n == 2) send_frame(TTC_BC0, 6'h00);
    end

    write_word(reg_addr(0), next_bits(32));  // reg 0 is read-only
    read_word(reg_addr(0));
    d        = next_bits(32);
    d[23:18] = START_MARK;                   // marker inside a body frame
    write_word(reg_addr(7), d);
    read_word(reg_addr(7));

    read_word({8'h41, 24'(next_bits(24))});
    a       = reg_addr(3);
    a[23:6] = 18'(next_bits(18)) | 18'd1;
    read_word(a);
    write_word({REG_BASE, 18'd1, 4'd4, 2'b00}, next_bits(32)); // must not land in reg 4
    read_word(reg_addr(4));

    k = 5 + int'(next_bits(3));
    for (int i = 0; i < k; i++) begin
      send_frame((i % 3 == 0) ? TTC_CAL : TTC_L1A, 6'h00);
      if (i % 3 != 0) l1a_model++;
    end
    read_word(reg_addr(0));
    send_frame(TTC_RES_L1A, 6'h00);          // clear beats the count
    l1a_model = 0;
    read_word(reg_addr(0));
    repeat (2) send_frame(TTC_L1A, 6'h00);
    l1a_model = 2;
    read_word(reg_addr(0));

    send_noise(20);
    send_request(1'b0, 1'b1, reg_addr(2), ~reg_model[2]);
    send_request(1'b0, 1'b0, reg_addr(9), '0);
    send_noise(20);
    read_word(reg_addr(2));

    read_word(reg_addr(1 + int'(next_bits(4)) % 15)); // tx stays busy
    read_word(reg_addr(0));
    read_word({8'h00, 24'(next_bits(24))});

    repeat (3600) send_frame(TTC_NONE, 6'h00); // bx wraps past 3563

    while (exp_q.size() != 0 || col_active) @(negedge clk40);
    repeat (40) @(negedge clk40);            // room for a stray packet
    if (exp_q.size() != 0 || col_active) begin
      report_fault("responses still outstanding at the end of the run");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYC) @(posedge clk40);
    report_fault("watchdog expired before the test sequence finished");
  end

endmodule
